/* hw/ip_tx_pkg.sv */
// framer widths, IPv4 constants, header and stream beat structs
`default_nettype none

package ip_tx_pkg;

  localparam int DATA_BYTES = 8;
  localparam int DATA_W = DATA_BYTES * 8;
  // payload lands four lanes up behind the 20-byte header
  localparam int SHIFT_BYTES = 4;
  localparam logic [3:0] IP_VERSION = 4'd4;
  localparam logic [3:0] IP_IHL = 4'd5;
  localparam int IP_HDR_BYTES = 20;
  localparam int SUM_W = 20;

  typedef struct packed {
    logic [47:0] dest_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
  } eth_hdr_t;

  typedef struct packed {
    logic [5:0]  dscp;
    logic [1:0]  ecn;
    logic [15:0] length;
    logic [15:0] identification;
    logic [2:0]  flags;
    logic [12:0] fragment_offset;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    logic [31:0] source_ip;
    logic [31:0] dest_ip;
  } ip_hdr_t;

  typedef struct packed {
    logic [DATA_W-1:0]     data;
    logic [DATA_BYTES-1:0] keep;
    logic                  last;
    logic                  user;
  } axis_beat_t;

endpackage

`default_nettype wire

/* hw/ip_hdr_latch.sv */
// header register block, checksum sum and Ethernet header handshake
`timescale 1ns/1ns
`default_nettype none

module ip_hdr_latch (
  input  logic                clk,
  input  logic                rst,
  input  logic                s_hdr_valid,
  output logic                s_hdr_ready,
  input  ip_tx_pkg::eth_hdr_t s_eth_hdr,
  input  ip_tx_pkg::ip_hdr_t  s_ip_hdr,
  input  logic                idle,
  output logic                hdr_start,
  output ip_tx_pkg::ip_hdr_t  ip_hdr,
  output logic [15:0]         hdr_csum,
  output logic                m_eth_hdr_valid,
  input  logic                m_eth_hdr_ready,
  output ip_tx_pkg::eth_hdr_t m_eth_hdr
);

  logic                        accept;
  logic                        eth_valid_next;
  logic [ip_tx_pkg::SUM_W-1:0] sum_next;
  logic [ip_tx_pkg::SUM_W-1:0] sum_q;
  logic [16:0]                 fold1;
  logic [15:0]                 fold2;

  assign accept = s_hdr_valid && s_hdr_ready;
  assign eth_valid_next = accept || (m_eth_hdr_valid && !m_eth_hdr_ready);

  // all nine header words, checksum word counted as zero
  assign sum_next = {ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL, s_ip_hdr.dscp, s_ip_hdr.ecn}
                  + s_ip_hdr.length
                  + s_ip_hdr.identification
                  + {s_ip_hdr.flags, s_ip_hdr.fragment_offset}
                  + {s_ip_hdr.ttl, s_ip_hdr.protocol}
                  + s_ip_hdr.source_ip[31:16]
                  + s_ip_hdr.source_ip[15:0]
                  + s_ip_hdr.dest_ip[31:16]
                  + s_ip_hdr.dest_ip[15:0];

  // end-around carry, second fold catches the carry of the first
  assign fold1 = sum_q[15:0] + sum_q[ip_tx_pkg::SUM_W-1:16];
  assign fold2 = fold1[15:0] + fold1[16];
  assign hdr_csum = ~fold2;

  always_ff @(posedge clk) begin
    if (rst) begin
      s_hdr_ready <= 1'b0;
      hdr_start <= 1'b0;
      m_eth_hdr_valid <= 1'b0;
    end else begin
      // next header waits for an idle framer and a taken Ethernet header
      s_hdr_ready <= idle && !hdr_start && !eth_valid_next;
      hdr_start <= accept;
      m_eth_hdr_valid <= eth_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      m_eth_hdr <= s_eth_hdr;
      ip_hdr <= s_ip_hdr;
      sum_q <= sum_next;
    end
  end

  a_eth_hdr_stable: assert property (@(posedge clk) disable iff (rst)
    m_eth_hdr_valid && !m_eth_hdr_ready |=> $stable(m_eth_hdr))
    else $error("[ERROR] %0t m_eth_hdr changed while waiting for ready", $time);

endmodule

`default_nettype wire

/* hw/payload_shifter.sv */
// four-lane payload realignment with saved word and flush beat
`timescale 1ns/1ns
`default_nettype none

module payload_shifter (
  input  logic                  clk,
  input  logic                  rst,
  input  ip_tx_pkg::axis_beat_t s_payload,
  input  logic                  s_payload_valid,
  output logic                  s_payload_ready,
  input  logic                  accept_en,
  input  logic                  take,
  input  logic                  flush,
  output ip_tx_pkg::axis_beat_t shifted,
  output logic                  shifted_valid
);

  ip_tx_pkg::axis_beat_t save_q;
  logic                  extra_q;
  logic                  in_fire;
  logic                  spill;

  assign s_payload_ready = accept_en && !extra_q;
  assign in_fire = s_payload_valid && s_payload_ready;
  // bytes in the upper lanes land in the following beat
  assign spill = |s_payload.keep[ip_tx_pkg::DATA_BYTES-1:ip_tx_pkg::SHIFT_BYTES];

  always_comb begin
    shifted.data[31:0] = save_q.data[63:32];
    shifted.keep[3:0] = save_q.keep[7:4];
    if (extra_q) begin
      // flush beat carries only the spilled bytes
      shifted.data[63:32] = 32'd0;
      shifted.keep[7:4] = 4'd0;
      shifted.last = save_q.last;
      shifted.user = save_q.user;
      shifted_valid = 1'b1;
    end else begin
      shifted.data[63:32] = s_payload.data[31:0];
      shifted.keep[7:4] = s_payload.keep[3:0];
      shifted.last = s_payload.last && !spill;
      shifted.user = s_payload.user && s_payload.last && !spill;
      shifted_valid = s_payload_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      extra_q <= 1'b0;
    end else if (flush) begin
      extra_q <= 1'b0;
    end else if (take) begin
      extra_q <= !extra_q && s_payload.last && spill;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      save_q <= s_payload;
    end
  end

  // a spilled last beat must leave a flush beat owed, with input held off
  a_no_input_while_owed: assert property (@(posedge clk) disable iff (rst)
    in_fire && s_payload.last && spill |=> extra_q && !s_payload_ready)
    else $error("[ERROR] %0t flush beat not owed after a spilled last beat", $time);

endmodule

`default_nettype wire

/* hw/ip_tx_ctrl.sv */
// framing FSM: header words, length count, keep trim, early termination
`timescale 1ns/1ns
`default_nettype none

module ip_tx_ctrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  hdr_start,
  input  ip_tx_pkg::ip_hdr_t    ip_hdr,
  input  logic [15:0]           hdr_csum,
  output logic                  idle,
  input  ip_tx_pkg::axis_beat_t shifted,
  input  logic                  shifted_valid,
  output logic                  accept_en,
  output logic                  take,
  output logic                  flush,
  output ip_tx_pkg::axis_beat_t beat,
  output logic                  beat_valid,
  input  logic                  buf_ready,
  output logic                  error_early_term
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR,
    ST_HDR_LAST,
    ST_PAYLOAD,
    ST_TRIM,
    ST_DRAIN
  } state_t;

  state_t                state_q;
  state_t                state_d;
  logic                  hdr_idx_q;
  logic [15:0]           remain_q;
  logic [15:0]           remain_d;
  ip_tx_pkg::axis_beat_t hold_q;
  logic                  hold_load;
  logic                  err_d;
  ip_tx_pkg::axis_beat_t cand;
  logic [3:0]            cand_count;
  logic [63:0]           word0;
  logic [63:0]           word1;

  function automatic logic [15:0] bswap16(input logic [15:0] v);
    return {v[7:0], v[15:8]};
  endfunction

  function automatic logic [31:0] bswap32(input logic [31:0] v);
    return {v[7:0], v[15:8], v[23:16], v[31:24]};
  endfunction

  // valid lanes counted from lane 0 up to the first gap
  function automatic logic [3:0] keep_count(input logic [7:0] k);
    logic [3:0] n;
    logic       run;
    n = 4'd0;
    run = 1'b1;
    for (int i = 0; i < ip_tx_pkg::DATA_BYTES; i++) begin
      if (!k[i]) begin
        run = 1'b0;
      end
      if (run) begin
        n = n + 4'd1;
      end
    end
    return n;
  endfunction

  function automatic logic [7:0] keep_mask(input logic [15:0] n);
    if (n >= 16'd8) begin
      return 8'hff;
    end
    return 8'hff >> (4'd8 - n[3:0]);
  endfunction

  // lane 0 is the first byte on the wire
  assign word0 = {bswap16({ip_hdr.flags, ip_hdr.fragment_offset}),
                  bswap16(ip_hdr.identification), bswap16(ip_hdr.length),
                  ip_hdr.dscp, ip_hdr.ecn, ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL};
  assign word1 = {bswap32(ip_hdr.source_ip), bswap16(hdr_csum), ip_hdr.protocol, ip_hdr.ttl};

  assign idle = (state_q == ST_IDLE);
  assign flush = (state_q == ST_IDLE);
  assign accept_en = (state_q == ST_DRAIN) ||
                     (buf_ready && (state_q inside {ST_HDR_LAST, ST_PAYLOAD, ST_TRIM}));
  assign take = accept_en && shifted_valid;

  // destination IP shares its word with the first payload lanes
  always_comb begin
    cand = shifted;
    if (state_q == ST_HDR_LAST) begin
      cand.data = {shifted.data[63:32], bswap32(ip_hdr.dest_ip)};
      cand.keep = {shifted.keep[7:4], 4'hf};
    end
    cand_count = keep_count(cand.keep);
  end

  always_comb begin
    state_d = state_q;
    remain_d = remain_q;
    hold_load = 1'b0;
    err_d = 1'b0;
    beat = '0;
    beat_valid = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (hdr_start) begin
          // bytes from the destination IP onwards
          remain_d = ip_hdr.length - 16'(ip_tx_pkg::IP_HDR_BYTES - ip_tx_pkg::SHIFT_BYTES);
          state_d = ST_HDR;
        end
      end
      ST_HDR: begin
        beat.data = hdr_idx_q ? word1 : word0;
        beat.keep = 8'hff;
        beat_valid = buf_ready;
        if (buf_ready && hdr_idx_q) begin
          state_d = ST_HDR_LAST;
        end
      end
      ST_HDR_LAST, ST_PAYLOAD: begin
        if (take) begin
          beat = cand;
          remain_d = remain_q - 16'd8;
          if ({12'd0, cand_count} >= remain_q) begin
            beat.keep = keep_mask(remain_q);
            if (cand.last) begin
              beat_valid = 1'b1;
              state_d = ST_IDLE;
            end else begin
              // excess input follows, keep the final word back
              hold_load = 1'b1;
              state_d = ST_TRIM;
            end
          end else if (cand.last || cand_count != 4'd8) begin
            // frame ended short of the IP length
            beat.keep = keep_mask({12'd0, cand_count});
            beat.last = 1'b1;
            beat.user = 1'b1;
            beat_valid = 1'b1;
            err_d = 1'b1;
            state_d = cand.last ? ST_IDLE : ST_DRAIN;
          end else begin
            beat_valid = 1'b1;
            state_d = ST_PAYLOAD;
          end
        end
      end
      ST_TRIM: begin
        beat = hold_q;
        beat.last = 1'b1;
        beat.user = shifted.user;
        if (take && shifted.last) begin
          beat_valid = 1'b1;
          state_d = ST_IDLE;
        end
      end
      ST_DRAIN: begin
        if (take && shifted.last) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      hdr_idx_q <= 1'b0;
      error_early_term <= 1'b0;
    end else begin
      state_q <= state_d;
      error_early_term <= err_d;
      if (state_q == ST_HDR && buf_ready) begin
        hdr_idx_q <= !hdr_idx_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    remain_q <= remain_d;
    if (hold_load) begin
      hold_q <= beat;
    end
  end

  a_last_keep_contiguous: assert property (@(posedge clk) disable iff (rst)
    beat_valid && beat.last |-> beat.keep[0] && (((beat.keep + 8'd1) & beat.keep) == 8'd0))
    else $error("[ERROR] %0t final beat keep %b not contiguous", $time, beat.keep);

endmodule

`default_nettype wire

/* hw/axis_skid_buffer.sv */
// two-register output stage with registered ready
`timescale 1ns/1ns
`default_nettype none

module axis_skid_buffer (
  input  logic                  clk,
  input  logic                  rst,
  input  ip_tx_pkg::axis_beat_t in_beat,
  input  logic                  in_valid,
  output logic                  in_ready,
  output ip_tx_pkg::axis_beat_t out_beat,
  output logic                  out_valid,
  input  logic                  out_ready
);

  ip_tx_pkg::axis_beat_t temp_beat;
  logic                  temp_valid;
  logic                  ready_early;
  logic                  in_to_out;
  logic                  in_to_temp;
  logic                  temp_to_out;

  // room next cycle if the sink drains or nothing is held
  assign ready_early = out_ready || (!temp_valid && !out_valid);

  assign in_to_out = in_ready && (out_ready || !out_valid);
  assign in_to_temp = in_ready && out_valid && !out_ready;
  assign temp_to_out = !in_ready && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_ready <= 1'b0;
      out_valid <= 1'b0;
      temp_valid <= 1'b0;
    end else begin
      in_ready <= ready_early;
      if (in_to_out) begin
        out_valid <= in_valid;
      end else if (temp_to_out) begin
        out_valid <= temp_valid;
        temp_valid <= 1'b0;
      end
      if (in_to_temp) begin
        temp_valid <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_to_out) begin
      out_beat <= in_beat;
    end else if (temp_to_out) begin
      out_beat <= temp_beat;
    end
    if (in_to_temp) begin
      temp_beat <= in_beat;
    end
  end

  a_temp_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    in_to_temp && in_valid |-> !temp_valid)
    else $error("[ERROR] %0t skid temp register overwritten", $time);

endmodule

`default_nettype wire

/* hw/ip_eth_tx.sv */
// IPv4 transmit framer top level
`timescale 1ns/1ns
`default_nettype none

module ip_eth_tx (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  s_hdr_valid,
  output logic                  s_hdr_ready,
  input  ip_tx_pkg::eth_hdr_t   s_eth_hdr,
  input  ip_tx_pkg::ip_hdr_t    s_ip_hdr,
  input  ip_tx_pkg::axis_beat_t s_payload,
  input  logic                  s_payload_valid,
  output logic                  s_payload_ready,
  output ip_tx_pkg::eth_hdr_t   m_eth_hdr,
  output logic                  m_eth_hdr_valid,
  input  logic                  m_eth_hdr_ready,
  output ip_tx_pkg::axis_beat_t m_payload,
  output logic                  m_payload_valid,
  input  logic                  m_payload_ready,
  output logic                  error_early_term
);

  logic                  idle;
  logic                  hdr_start;
  ip_tx_pkg::ip_hdr_t    ip_hdr;
  logic [15:0]           hdr_csum;
  logic                  accept_en;
  logic                  take;
  logic                  flush;
  ip_tx_pkg::axis_beat_t shifted;
  logic                  shifted_valid;
  ip_tx_pkg::axis_beat_t beat;
  logic                  beat_valid;
  logic                  buf_ready;

  ip_hdr_latch u_latch (
    .clk(clk), .rst(rst),
    .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
    .s_eth_hdr(s_eth_hdr), .s_ip_hdr(s_ip_hdr),
    .idle(idle), .hdr_start(hdr_start), .ip_hdr(ip_hdr), .hdr_csum(hdr_csum),
    .m_eth_hdr_valid(m_eth_hdr_valid), .m_eth_hdr_ready(m_eth_hdr_ready),
    .m_eth_hdr(m_eth_hdr)
  );

  payload_shifter u_shifter (
    .clk(clk), .rst(rst),
    .s_payload(s_payload), .s_payload_valid(s_payload_valid),
    .s_payload_ready(s_payload_ready),
    .accept_en(accept_en), .take(take), .flush(flush),
    .shifted(shifted), .shifted_valid(shifted_valid)
  );

  ip_tx_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .hdr_start(hdr_start), .ip_hdr(ip_hdr), .hdr_csum(hdr_csum), .idle(idle),
    .shifted(shifted), .shifted_valid(shifted_valid),
    .accept_en(accept_en), .take(take), .flush(flush),
    .beat(beat), .beat_valid(beat_valid), .buf_ready(buf_ready),
    .error_early_term(error_early_term)
  );

  axis_skid_buffer u_skid (
    .clk(clk), .rst(rst),
    .in_beat(beat), .in_valid(beat_valid), .in_ready(buf_ready),
    .out_beat(m_payload), .out_valid(m_payload_valid), .out_ready(m_payload_ready)
  );

endmodule

`default_nettype wire

/* test/tb_clock.sv */
// testbench clock source, 100 ns period
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam int HALF_PERIOD = 50;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

`default_nettype wire

/* test/ip_eth_tx_tb.sv */
// framer testbench: frame stimulus, reference bytes, output monitor, assertions, watchdog
`timescale 1ns/1ns
`default_nettype none

module ip_eth_tx_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_FRAMES = 72;
  localparam int MAX_FRAME_BEATS = 10;
  localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_FRAME_BEATS * 4 + 500;

  logic                  clk;
  logic                  rst;
  logic                  s_hdr_valid;
  logic                  s_hdr_ready;
  ip_tx_pkg::eth_hdr_t   s_eth_hdr;
  ip_tx_pkg::ip_hdr_t    s_ip_hdr;
  ip_tx_pkg::axis_beat_t s_payload;
  logic                  s_payload_valid;
  logic                  s_payload_ready;
  ip_tx_pkg::eth_hdr_t   m_eth_hdr;
  logic                  m_eth_hdr_valid;
  logic                  m_eth_hdr_ready;
  ip_tx_pkg::axis_beat_t m_payload;
  logic                  m_payload_valid;
  logic                  m_payload_ready;
  logic                  error_early_term;

  integer seed;
  integer ready_seed;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int err_pulses = 0;
  int exp_pulses = 0;
  bit bp_on = 1'b0;
  // expected output bytes of all frames in flight, in wire order
  logic [7:0] exp_bytes[$];
  int exp_len[$];
  bit exp_user[$];
  ip_tx_pkg::eth_hdr_t exp_eth[$];

  tb_clock u_clock (.clk(clk));

  ip_eth_tx uut (.*);

  task automatic log_error(input string msg);
    errors++;
    $display("[ERROR] %0t %s", $time, msg);
  endtask

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand32() % (hi - lo + 1));
  endfunction

  // one's-complement sum of the ten big-endian header words
  function automatic logic [15:0] ones_sum(input logic [7:0] h [ip_tx_pkg::IP_HDR_BYTES]);
    logic [31:0] s;
    s = 32'd0;
    for (int i = 0; i < ip_tx_pkg::IP_HDR_BYTES; i += 2) begin
      s = s + {16'd0, h[i], h[i+1]};
    end
    while (s[31:16] != 16'd0) begin
      s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
    end
    return s[15:0];
  endfunction

  task automatic send_frame(input int pay_len, input int in_len);
    ip_tx_pkg::eth_hdr_t   eth;
    ip_tx_pkg::ip_hdr_t    ip;
    ip_tx_pkg::axis_beat_t b;
    logic [7:0]            hdr [ip_tx_pkg::IP_HDR_BYTES];
    logic [7:0]            pay[$];
    logic [15:0]           csum;
    int                    nbeats;
    eth = 112'({rand32(), rand32(), rand32(), rand32()});
    ip = 136'({rand32(), rand32(), rand32(), rand32(), rand32()});
    ip.length = 16'(ip_tx_pkg::IP_HDR_BYTES + pay_len);
    hdr[0] = {ip_tx_pkg::IP_VERSION, ip_tx_pkg::IP_IHL};
    hdr[1] = {ip.dscp, ip.ecn};
    {hdr[2], hdr[3]} = ip.length;
    {hdr[4], hdr[5]} = ip.identification;
    {hdr[6], hdr[7]} = {ip.flags, ip.fragment_offset};
    hdr[8] = ip.ttl;
    hdr[9] = ip.protocol;
    {hdr[10], hdr[11]} = 16'd0;
    {hdr[12], hdr[13], hdr[14], hdr[15]} = ip.source_ip;
    {hdr[16], hdr[17], hdr[18], hdr[19]} = ip.dest_ip;
    csum = ~ones_sum(hdr);
    {hdr[10], hdr[11]} = csum;
    for (int i = 0; i < in_len; i++) begin
      pay.push_back(8'(rand32()));
    end
    foreach (hdr[i]) begin
      exp_bytes.push_back(hdr[i]);
    end
    for (int i = 0; i < in_len && i < pay_len; i++) begin
      exp_bytes.push_back(pay[i]);
    end
    exp_len.push_back(ip_tx_pkg::IP_HDR_BYTES + (in_len < pay_len ? in_len : pay_len));
    exp_user.push_back(in_len < pay_len);
    exp_eth.push_back(eth);
    if (in_len < pay_len) begin
      exp_pulses++;
    end
    // header handshake, ready is registered so it is stable at the falling edge
    s_eth_hdr = eth;
    s_ip_hdr = ip;
    s_hdr_valid = 1'b1;
    while (!s_hdr_ready) @(negedge clk);
    @(negedge clk);
    s_hdr_valid = 1'b0;
    nbeats = (in_len + ip_tx_pkg::DATA_BYTES - 1) / ip_tx_pkg::DATA_BYTES;
    for (int bi = 0; bi < nbeats; bi++) begin
      b = '0;
      for (int l = 0; l < ip_tx_pkg::DATA_BYTES; l++) begin
        if (bi * ip_tx_pkg::DATA_BYTES + l < in_len) begin
          b.data[l*8 +: 8] = pay[bi * ip_tx_pkg::DATA_BYTES + l];
          b.keep[l] = 1'b1;
        end
      end
      b.last = (bi == nbeats - 1);
      while (rand_range(0, 3) == 0) begin
        s_payload_valid = 1'b0;
        @(negedge clk);
      end
      s_payload = b;
      s_payload_valid = 1'b1;
      while (!s_payload_ready) @(negedge clk);
      @(negedge clk);
    end
    s_payload_valid = 1'b0;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    while (exp_len.size() != 0 || exp_eth.size() != 0) @(negedge clk);
    repeat (8) @(negedge clk);
    assert (err_pulses == exp_pulses)
      else log_error($sformatf("%0d error pulses, expected %0d", err_pulses, exp_pulses));
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - errors_before);
    end
  endtask

  // readies, output byte checks and error pulse count share one process
  initial begin : output_monitor
    logic [7:0] got;
    logic [7:0] want;
    logic [7:0] out_hdr [ip_tx_pkg::IP_HDR_BYTES];
    int         out_count;
    int         n;
    bit         u;
    out_count = 0;
    m_payload_ready = 1'b0;
    m_eth_hdr_ready = 1'b0;
    forever begin
      @(negedge clk);
      m_payload_ready = !bp_on || ($random(ready_seed) % 4 != 0);
      m_eth_hdr_ready = !bp_on || ($random(ready_seed) % 3 == 0);
      if (error_early_term) begin
        err_pulses++;
      end
      if (m_eth_hdr_valid && m_eth_hdr_ready) begin
        if (exp_eth.size() == 0) begin
          log_error("Ethernet header sent with none expected");
        end else begin
          assert (m_eth_hdr == exp_eth[0])
            else log_error($sformatf("eth header %h expected %h", m_eth_hdr, exp_eth[0]));
          void'(exp_eth.pop_front());
        end
      end
      if (m_payload_valid && m_payload_ready) begin
        for (int i = 0; i < ip_tx_pkg::DATA_BYTES; i++) begin
          if (m_payload.keep[i]) begin
            got = m_payload.data[i*8 +: 8];
            if (out_count < ip_tx_pkg::IP_HDR_BYTES) begin
              out_hdr[out_count] = got;
            end
            if (exp_bytes.size() == 0) begin
              log_error("output byte with no byte expected");
            end else begin
              want = exp_bytes.pop_front();
              assert (got == want)
                else log_error($sformatf("byte %0d is %h expected %h", out_count, got, want));
            end
            out_count++;
          end
        end
        if (m_payload.last) begin
          if (exp_len.size() == 0) begin
            log_error("frame end with no frame expected");
          end else begin
            n = exp_len.pop_front();
            u = exp_user.pop_front();
            assert (out_count == n)
              else log_error($sformatf("frame of %0d bytes expected %0d", out_count, n));
            assert (m_payload.user == u)
              else log_error($sformatf("last beat user %b expected %b", m_payload.user, u));
          end
          if (out_count >= ip_tx_pkg::IP_HDR_BYTES) begin
            assert (ones_sum(out_hdr) == 16'hffff)
              else log_error($sformatf("header re-sum %h", ones_sum(out_hdr)));
          end
          out_count = 0;
        end
      end
    end
  end

  a_payload_hold: assert property (@(posedge clk) disable iff (rst)
    m_payload_valid && !m_payload_ready |=> m_payload_valid && $stable(m_payload))
    else log_error("m_payload changed or dropped while stalled");

  a_eth_hold: assert property (@(posedge clk) disable iff (rst)
    m_eth_hdr_valid && !m_eth_hdr_ready |=> m_eth_hdr_valid && $stable(m_eth_hdr))
    else log_error("m_eth_hdr changed or dropped while stalled");

  a_error_one_cycle: assert property (@(posedge clk) disable iff (rst)
    error_early_term |=> !error_early_term)
    else log_error("error_early_term longer than one cycle");

  // only the last beat may be partial, and then filled from lane 0
  a_keep_shape: assert property (@(posedge clk) disable iff (rst)
    m_payload_valid |-> (m_payload.last ?
      (m_payload.keep != 8'd0 &&
       m_payload.keep == (8'hff >> (8 - $countones(m_payload.keep)))) :
      (m_payload.keep == 8'hff && !m_payload.user)))
    else log_error($sformatf("bad keep %b or user on beat", m_payload.keep));

  a_reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !s_hdr_ready && !s_payload_ready && !m_eth_hdr_valid &&
                          !m_payload_valid && !error_early_term)
    else log_error("output active during reset");

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    int eb;
    int p;
    int mode;
    seed = 32'hfdbb4229;
    ready_seed = $random(seed);
    rst = 1'b1;
    s_hdr_valid = 1'b0;
    s_eth_hdr = '0;
    s_ip_hdr = '0;
    s_payload = '0;
    s_payload_valid = 1'b0;
    eb = errors;
    repeat (5) @(negedge clk);
    assert (!s_hdr_ready && !s_payload_ready && !m_eth_hdr_valid && !m_payload_valid)
      else log_error("valid or ready high at end of reset");
    rst = 1'b0;
    @(negedge clk);
    assert (s_hdr_ready) else log_error("s_hdr_ready low after reset release");
    finish_test("reset", eb);

    // payload lengths cover every residue mod 8
    eb = errors;
    for (int i = 1; i <= 24; i++) begin
      send_frame(i, i);
    end
    finish_test("exact_length", eb);

    eb = errors;
    for (int i = 0; i < 12; i++) begin
      p = rand_range(1, 40);
      send_frame(p, p + rand_range(1, 16));
    end
    finish_test("long_input", eb);

    eb = errors;
    for (int i = 0; i < 12; i++) begin
      p = rand_range(2, 40);
      send_frame(p, rand_range(1, p - 1));
    end
    finish_test("short_input", eb);

    eb = errors;
    @(posedge clk);
    bp_on = 1'b1;
    @(negedge clk);
    for (int i = 0; i < 24; i++) begin
      p = rand_range(2, 40);
      mode = rand_range(0, 2);
      if (mode == 0) begin
        send_frame(p, p);
      end else if (mode == 1) begin
        send_frame(p, p + rand_range(1, 16));
      end else begin
        send_frame(p, rand_range(1, p - 1));
      end
    end
    finish_test("back_pressure", eb);

    $display("tests run %0d, passed %0d, failed %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0 && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hw/ip_tx_pkg.sv
hw/ip_hdr_latch.sv
hw/payload_shifter.sv
hw/ip_tx_ctrl.sv
hw/axis_skid_buffer.sv
hw/ip_eth_tx.sv
test/tb_clock.sv
test/ip_eth_tx_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the framer testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ip_eth_tx_tb \
  --Mdir obj_dir -o sim_tb -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
